/* source/taint_params.svh */
`ifndef TAINT_PARAMS_SVH
`define TAINT_PARAMS_SVH

// operand and taint mask width
`define TT_DATA_W 16

// request tag width
`define TT_TAG_W 4

// input buffer depth, also the upstream sender's starting credits
`define TT_IN_DEPTH 4

// output buffer depth, also the input buffer's credits toward it
`define TT_OUT_DEPTH 4

// credits held toward the external receiver after reset
`define TT_OUT_CREDITS 2

// bits needed to express TT_DATA_W
`define TT_SHAMT_W 5

`endif

/* source/taint_pkg.sv */
`default_nettype none

`include "taint_params.svh"

package taint_pkg;

    // cell rule selector
    typedef enum logic [3:0] {
        OP_AND     = 4'd0,
        OP_OR      = 4'd1,
        OP_XOR     = 4'd2,
        OP_EQ      = 4'd3,
        OP_SHL     = 4'd4,
        OP_SHR     = 4'd5,
        OP_MUL     = 4'd6,
        OP_NOT     = 4'd7,
        OP_RED_AND = 4'd8,
        OP_RED_XOR = 4'd9,
        OP_MUX     = 4'd10
    } taint_op_e;

    // one request: operands, their masks and the mux select
    typedef struct packed {
        logic [`TT_TAG_W-1:0]  tag;
        taint_op_e             op;
        logic [`TT_DATA_W-1:0] a;
        logic [`TT_DATA_W-1:0] b;
        logic [`TT_DATA_W-1:0] a_taint;
        logic [`TT_DATA_W-1:0] b_taint;
        logic                  sel;
        logic                  sel_taint;
    } taint_req_t;

    typedef struct packed {
        logic [`TT_TAG_W-1:0]  tag;
        logic [`TT_DATA_W-1:0] y_taint;
    } taint_rsp_t;

endpackage

`default_nettype wire

/* source/credit_link_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one-way item link with a credit return path
interface credit_link_if #(
    parameter type payload_t = logic
) ();

    // one cycle per item, only while a credit is held
    logic     valid;
    payload_t payload;
    // one cycle per freed slot at the receiver
    logic     credit;

    modport sender (
        output valid,
        output payload,
        input  credit
    );

    modport receiver (
        input  valid,
        input  payload,
        output credit
    );

endinterface

`default_nettype wire

/* source/credit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
    parameter type payload_t    = logic,
    parameter int  DEPTH        = 4,
    parameter int  INIT_CREDITS = 4
) (
    input logic               pos_clk,
    input logic               pos_arst,
    credit_link_if.receiver   up,
    credit_link_if.sender     down
);

    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int CRED_W = $clog2(INIT_CREDITS + 1);

    payload_t          mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  fill;
    logic [CRED_W-1:0] credits;
    logic              send;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // head leaves as soon as there is an item and a downstream slot
    assign send         = (fill != '0) && (credits != '0);
    assign down.valid   = send;
    assign down.payload = mem[rd_ptr];
    // the slot freed by a send goes back upstream at once
    assign up.credit    = send;

    always_ff @(posedge pos_clk) begin
        if (up.valid) begin
            mem[wr_ptr] <= up.payload;
        end
    end

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (up.valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (send) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({up.valid, send})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

    // downstream credit count, one spent per send
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            credits <= CRED_W'(INIT_CREDITS);
        end else begin
            case ({send, down.credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // upstream must only send against credits we handed out
    a_no_push_when_full: assert property (
        @(posedge pos_clk) disable iff (pos_arst)
        up.valid |-> (fill < CNT_W'(DEPTH))
    ) else $error("push into a full buffer");

    // receiver returns no more credits than it started with
    a_credit_bound: assert property (
        @(posedge pos_clk) disable iff (pos_arst)
        credits <= CRED_W'(INIT_CREDITS)
    ) else $error("downstream credit count above its initial value");

endmodule

`default_nettype wire

/* source/taint_prop_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "taint_params.svh"

module taint_prop_unit
    import taint_pkg::*;
(
    input logic             pos_clk,
    input logic             pos_arst,
    credit_link_if.receiver req,
    credit_link_if.sender   rsp
);

    localparam int W = `TT_DATA_W;

    logic        rsp_valid;
    taint_rsp_t  rsp_q;

    // conservative per-cell rules, single-bit results land in bit 0
    function automatic logic [W-1:0] calc_taint(input taint_req_t r);
        logic [W-1:0] at;
        logic [W-1:0] bt;
        logic [W-1:0] keep;
        logic [W-1:0] y;
        at   = r.a_taint;
        bt   = r.b_taint;
        // untainted positions in both operands
        keep = ~(at | bt);
        y    = '0;
        case (r.op)
            OP_AND: y = (at & r.b) | (bt & r.a) | (at & bt);
            OP_OR:  y = (at & ~r.b) | (bt & ~r.a) | (at & bt);
            OP_EQ:  y[0] = ((r.a & keep) == (r.b & keep)) && (|{at, bt});
            OP_SHL, OP_SHR: begin
                if (|bt) begin
                    y = '1;
                end else if (r.b >= W) begin
                    y = '0;
                end else if (r.op == OP_SHL) begin
                    y = at << r.b[`TT_SHAMT_W-1:0];
                end else begin
                    y = at >> r.b[`TT_SHAMT_W-1:0];
                end
            end
            OP_MUL: y = {W{|{at, bt}}};
            // no untainted one bit may decide the result
            OP_NOT:     y[0] = (|at) && !(|(~at & r.a));
            OP_RED_AND: y[0] = (&(at | r.a)) && (|at);
            OP_RED_XOR: y[0] = |at;
            OP_MUX: begin
                y = r.sel ? bt : at;
                // select difference taken as always possible
                if (r.sel_taint) begin
                    y = y | (r.a ^ r.b);
                end
            end
            // xor, add and the rest
            default: y = at | bt;
        endcase
        return y;
    endfunction

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= req.valid;
        end
    end

    always_ff @(posedge pos_clk) begin
        if (req.valid) begin
            rsp_q.tag     <= req.payload.tag;
            rsp_q.y_taint <= calc_taint(req.payload);
        end
    end

    assign rsp.valid   = rsp_valid;
    assign rsp.payload = rsp_q;
    // no storage here, so a slot freed downstream is a slot for us
    assign req.credit  = rsp.credit;

    a_op_defined: assert property (
        @(posedge pos_clk) disable iff (pos_arst)
        req.valid |-> (req.payload.op inside {OP_AND, OP_OR, OP_XOR, OP_EQ, OP_SHL,
                                              OP_SHR, OP_MUL, OP_NOT, OP_RED_AND,
                                              OP_RED_XOR, OP_MUX})
    ) else $error("undefined op code %0d", req.payload.op);

endmodule

`default_nettype wire

/* source/taint_tracker_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "taint_params.svh"

module taint_tracker_top
    import taint_pkg::*;
(
    input  logic                          pos_clk,
    input  logic                          pos_arst,
    // request side
    input  logic                          in_valid,
    input  logic [`TT_TAG_W-1:0]          in_tag,
    input  logic [$bits(taint_op_e)-1:0]  in_op,
    input  logic [`TT_DATA_W-1:0]         in_a,
    input  logic [`TT_DATA_W-1:0]         in_b,
    input  logic [`TT_DATA_W-1:0]         in_a_taint,
    input  logic [`TT_DATA_W-1:0]         in_b_taint,
    input  logic                          in_sel,
    input  logic                          in_sel_taint,
    output logic                          in_credit,
    // response side
    output logic                          out_valid,
    output logic [`TT_TAG_W-1:0]          out_tag,
    output logic [`TT_DATA_W-1:0]         out_y_taint,
    input  logic                          out_credit
);

    credit_link_if #(.payload_t(taint_req_t)) in_link ();
    credit_link_if #(.payload_t(taint_req_t)) req_link ();
    credit_link_if #(.payload_t(taint_rsp_t)) rsp_link ();
    credit_link_if #(.payload_t(taint_rsp_t)) out_link ();

    // pack the request fields
    assign in_link.valid   = in_valid;
    assign in_link.payload = '{
        tag:       in_tag,
        op:        taint_op_e'(in_op),
        a:         in_a,
        b:         in_b,
        a_taint:   in_a_taint,
        b_taint:   in_b_taint,
        sel:       in_sel,
        sel_taint: in_sel_taint
    };
    assign in_credit       = in_link.credit;

    // unpack the response
    assign out_valid       = out_link.valid;
    assign out_tag         = out_link.payload.tag;
    assign out_y_taint     = out_link.payload.y_taint;
    assign out_link.credit = out_credit;

    // credits toward the prop unit mirror the egress free slots
    credit_fifo #(
        .payload_t    (taint_req_t),
        .DEPTH        (`TT_IN_DEPTH),
        .INIT_CREDITS (`TT_OUT_DEPTH)
    ) u_ingress (
        .pos_clk  (pos_clk),
        .pos_arst (pos_arst),
        .up       (in_link),
        .down     (req_link)
    );

    taint_prop_unit u_prop (
        .pos_clk  (pos_clk),
        .pos_arst (pos_arst),
        .req      (req_link),
        .rsp      (rsp_link)
    );

    credit_fifo #(
        .payload_t    (taint_rsp_t),
        .DEPTH        (`TT_OUT_DEPTH),
        .INIT_CREDITS (`TT_OUT_CREDITS)
    ) u_egress (
        .pos_clk  (pos_clk),
        .pos_arst (pos_arst),
        .up       (rsp_link),
        .down     (out_link)
    );

endmodule

`default_nettype wire

/* dv/taint_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "taint_params.svh"

module taint_checker #(
    parameter int N_ROWS = 1,
    parameter int NAME_W = 128
) (
    input  logic                  pos_clk,
    input  logic                  pos_arst,
    // request side, expected result rides along with it
    input  logic                  in_valid,
    input  logic [`TT_TAG_W-1:0]  in_tag,
    input  logic [NAME_W-1:0]     exp_name,
    input  logic [`TT_DATA_W-1:0] exp_y,
    input  logic                  in_credit,
    // response side
    input  logic                  out_valid,
    input  logic [`TT_TAG_W-1:0]  out_tag,
    input  logic [`TT_DATA_W-1:0] out_y_taint,
    input  logic                  hold,
    output int                    n_pass,
    output int                    n_fail,
    output int                    n_checked,
    output logic                  all_done
);

    logic [NAME_W-1:0]     name_q [$];
    logic [`TT_TAG_W-1:0]  tag_q  [$];
    logic [`TT_DATA_W-1:0] y_q    [$];
    logic [NAME_W-1:0]     e_name;
    logic [`TT_TAG_W-1:0]  e_tag;
    logic [`TT_DATA_W-1:0] e_y;
    int                    items_sent;
    int                    credit_pulses;
    int                    hold_results;

    // results must come back in request order
    task automatic compare_result();
        if (tag_q.size() == 0) begin
            $display("result with tag %0d arrived with no request outstanding", out_tag);
            n_fail = n_fail + 1;
        end else begin
            e_name = name_q.pop_front();
            e_tag  = tag_q.pop_front();
            e_y    = y_q.pop_front();
            if (out_tag !== e_tag || out_y_taint !== e_y) begin
                $display("Fail %0s: expected tag %0d y_taint %h, actual tag %0d y_taint %h",
                         e_name, e_tag, e_y, out_tag, out_y_taint);
                n_fail = n_fail + 1;
            end else begin
                $display("Pass %0s", e_name);
                n_pass = n_pass + 1;
            end
            n_checked = n_checked + 1;
            if (n_checked == N_ROWS) begin
                // every request has left the ingress buffer by now
                if (credit_pulses != N_ROWS) begin
                    $display("in_credit pulsed %0d times for %0d requests",
                             credit_pulses, N_ROWS);
                    n_fail = n_fail + 1;
                end
                all_done <= 1'b1;
            end
        end
    endtask

    always @(posedge pos_clk) begin
        if (pos_arst) begin
            n_pass        = 0;
            n_fail        = 0;
            n_checked     = 0;
            items_sent    = 0;
            credit_pulses = 0;
            hold_results  = 0;
            name_q.delete();
            tag_q.delete();
            y_q.delete();
            all_done <= 1'b0;
        end else begin
            if (in_valid) begin
                items_sent = items_sent + 1;
                name_q.push_back(exp_name);
                tag_q.push_back(in_tag);
                y_q.push_back(exp_y);
            end
            if (in_credit) begin
                credit_pulses = credit_pulses + 1;
                if (credit_pulses > items_sent) begin
                    $display("in_credit pulse %0d with only %0d requests sent",
                             credit_pulses, items_sent);
                    n_fail = n_fail + 1;
                end
            end
            // only the initial egress credits may be spent while credits are held back
            if (out_valid && hold) begin
                hold_results = hold_results + 1;
                if (hold_results > `TT_OUT_CREDITS) begin
                    $display("result %0d sent during the hold window without a credit",
                             hold_results);
                    n_fail = n_fail + 1;
                end
            end
            if (out_valid) begin
                compare_result();
            end
        end
    end

endmodule

`default_nettype wire

/* dv/taint_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "taint_params.svh"

module taint_tb
    import taint_pkg::*;
();

    localparam int N_ROWS         = 24;
    localparam int NAME_W         = 128;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = N_ROWS * 20 + RESET_CYCLES;
    // cycles after reset release with no out_credit returned
    localparam int HOLD_START     = 8;
    localparam int HOLD_LEN       = 40;

    logic                         pos_clk;
    logic                         pos_arst;
    logic                         in_valid;
    logic [`TT_TAG_W-1:0]         in_tag;
    logic [$bits(taint_op_e)-1:0] in_op;
    logic [`TT_DATA_W-1:0]        in_a;
    logic [`TT_DATA_W-1:0]        in_b;
    logic [`TT_DATA_W-1:0]        in_a_taint;
    logic [`TT_DATA_W-1:0]        in_b_taint;
    logic                         in_sel;
    logic                         in_sel_taint;
    logic                         in_credit;
    logic                         out_valid;
    logic [`TT_TAG_W-1:0]         out_tag;
    logic [`TT_DATA_W-1:0]        out_y_taint;
    logic                         out_credit;
    logic                         hold;
    logic [NAME_W-1:0]            exp_name;
    logic [`TT_DATA_W-1:0]        exp_y;
    int                           n_pass;
    int                           n_fail;
    int                           n_checked;
    logic                         all_done;

    // stimulus table with the tag taken as row index modulo 16
    taint_req_t                   row_req  [N_ROWS];
    logic [NAME_W-1:0]            row_name [N_ROWS];
    logic [`TT_DATA_W-1:0]        row_y    [N_ROWS];
    int                           n_rows;
    int                           row;
    int                           up_credits;
    int                           run_cycle;
    int                           tb_cycles;
    int                           delay;
    int                           due_q [$];
    logic                         in_hold;
    integer                       seed = 37;

    taint_tracker_top uut (.*);

    taint_checker #(.N_ROWS(N_ROWS), .NAME_W(NAME_W)) u_checker (.*);

    task automatic add_row(input logic [NAME_W-1:0] name, input taint_op_e op,
                           input logic [`TT_DATA_W-1:0] a, b, at, bt,
                           input logic sel, st, input logic [`TT_DATA_W-1:0] y);
        row_name[n_rows] = name;
        row_req[n_rows]  = '{tag: `TT_TAG_W'(n_rows), op: op, a: a, b: b, a_taint: at,
                             b_taint: bt, sel: sel, sel_taint: st};
        row_y[n_rows]    = y;
        n_rows           = n_rows + 1;
    endtask

    task automatic send_row(input int i);
        in_valid     <= 1'b1;
        in_tag       <= row_req[i].tag;
        in_op        <= row_req[i].op;
        in_a         <= row_req[i].a;
        in_b         <= row_req[i].b;
        in_a_taint   <= row_req[i].a_taint;
        in_b_taint   <= row_req[i].b_taint;
        in_sel       <= row_req[i].sel;
        in_sel_taint <= row_req[i].sel_taint;
        exp_name     <= row_name[i];
        exp_y        <= row_y[i];
    endtask

    initial begin
        pos_clk = 1'b0;
        forever begin
            #2 pos_clk = ~pos_clk;
        end
    end

    // each out_credit goes back 0 to 6 cycles after its result
    always @(posedge pos_clk) begin
        if (pos_arst) begin
            run_cycle = 0;
            hold       <= 1'b0;
            out_credit <= 1'b0;
        end else begin
            run_cycle = run_cycle + 1;
            if (out_valid) begin
                delay = $unsigned($random(seed)) % 7;
                due_q.push_back(run_cycle + delay);
            end
            in_hold = (run_cycle >= HOLD_START) && (run_cycle < HOLD_START + HOLD_LEN);
            hold <= in_hold;
            if (!in_hold && due_q.size() != 0 && due_q[0] <= run_cycle) begin
                void'(due_q.pop_front());
                out_credit <= 1'b1;
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    always @(posedge pos_clk) begin
        tb_cycles = tb_cycles + 1;
        if (tb_cycles >= TIMEOUT_CYCLES && !all_done) begin
            $display("timeout after %0d cycles, %0d of %0d results missing",
                     tb_cycles, N_ROWS - n_checked, N_ROWS);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        {in_valid, in_tag, in_op, in_a, in_b, in_a_taint, in_b_taint, in_sel,
         in_sel_taint} = '0;
        out_credit = 1'b0;
        hold       = 1'b0;
        exp_name   = '0;
        exp_y      = '0;
        pos_arst   = 1'b1;
        n_rows     = 0;
        //      name           op          a         b         at        bt      sel   st
        add_row("and_clean", OP_AND, 16'hffff, 16'hffff, 16'h0000, 16'h0000, 1'b0, 1'b0, 16'h0000);
        add_row("and_mix", OP_AND, 16'hf0f0, 16'h0ff0, 16'h00ff, 16'h0000, 1'b0, 1'b0, 16'h00f0);
        add_row("and_both", OP_AND, 16'h1234, 16'h0000, 16'hff00, 16'h0f0f, 1'b0, 1'b0, 16'h0f04);
        add_row("or_mix", OP_OR, 16'h00f0, 16'h0f0f, 16'hffff, 16'h0000, 1'b0, 1'b0, 16'hf0f0);
        add_row("or_both", OP_OR, 16'hff00, 16'h0000, 16'h000f, 16'h0ff0, 1'b0, 1'b0, 16'h00ff);
        add_row("xor_mix", OP_XOR, 16'h0000, 16'h0000, 16'h1200, 16'h0034, 1'b0, 1'b0, 16'h1234);
        add_row("eq_same", OP_EQ, 16'h1234, 16'h1230, 16'h000f, 16'h0000, 1'b0, 1'b0, 16'h0001);
        add_row("eq_diff", OP_EQ, 16'h1234, 16'h5234, 16'h000f, 16'h0000, 1'b0, 1'b0, 16'h0000);
        add_row("eq_clean", OP_EQ, 16'h0005, 16'h0005, 16'h0000, 16'h0000, 1'b0, 1'b0, 16'h0000);
        add_row("not_set", OP_NOT, 16'h00f0, 16'h0000, 16'h00ff, 16'h0000, 1'b0, 1'b0, 16'h0001);
        add_row("not_clear", OP_NOT, 16'h0100, 16'h0000, 16'h00ff, 16'h0000, 1'b0, 1'b0, 16'h0000);
        add_row("rand_set", OP_RED_AND, 16'hff00, 16'h0, 16'h00ff, 16'h0, 1'b0, 1'b0, 16'h0001);
        add_row("rand_clear", OP_RED_AND, 16'hfe00, 16'h0, 16'h00ff, 16'h0, 1'b0, 1'b0, 16'h0000);
        add_row("rxor_set", OP_RED_XOR, 16'h0000, 16'h0, 16'h0400, 16'h0, 1'b0, 1'b0, 16'h0001);
        add_row("rxor_clear", OP_RED_XOR, 16'hffff, 16'h0, 16'h0000, 16'h0, 1'b0, 1'b0, 16'h0000);
        add_row("shl_tnt_amt", OP_SHL, 16'h0000, 16'h0003, 16'h0001, 16'h0001, 1'b0, 1'b0, 16'hffff);
        add_row("shl_ord", OP_SHL, 16'h0000, 16'h0004, 16'h00f3, 16'h0000, 1'b0, 1'b0, 16'h0f30);
        add_row("shl_big", OP_SHL, 16'h0000, 16'h0024, 16'hffff, 16'h0000, 1'b0, 1'b0, 16'h0000);
        add_row("shr_ord", OP_SHR, 16'h0000, 16'h0008, 16'hf000, 16'h0000, 1'b0, 1'b0, 16'h00f0);
        add_row("mul_taint", OP_MUL, 16'h0003, 16'h0005, 16'h0000, 16'h0001, 1'b0, 1'b0, 16'hffff);
        add_row("mul_clean", OP_MUL, 16'h0003, 16'h0005, 16'h0000, 16'h0000, 1'b0, 1'b0, 16'h0000);
        add_row("mux_sel0", OP_MUX, 16'h0000, 16'h0000, 16'h00ff, 16'hff00, 1'b0, 1'b0, 16'h00ff);
        add_row("mux_sel1", OP_MUX, 16'h0000, 16'h0000, 16'h00ff, 16'hff00, 1'b1, 1'b0, 16'hff00);
        add_row("mux_sel_tnt", OP_MUX, 16'h1234, 16'h1200, 16'h000f, 16'h0, 1'b0, 1'b1, 16'h003f);
        repeat (RESET_CYCLES) @(posedge pos_clk);
        pos_arst <= 1'b0;
        // upstream starts with one credit per ingress slot
        row        = 0;
        up_credits = `TT_IN_DEPTH;
        while (row < N_ROWS) begin
            @(posedge pos_clk);
            if (in_credit) begin
                up_credits = up_credits + 1;
            end
            if (up_credits > 0) begin
                send_row(row);
                up_credits = up_credits - 1;
                row        = row + 1;
            end else begin
                in_valid <= 1'b0;
            end
        end
        @(posedge pos_clk);
        in_valid <= 1'b0;
        while (!all_done) begin
            @(posedge pos_clk);
        end
        @(negedge pos_clk);
        $display("tests passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0 && n_pass == N_ROWS) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+source
source/taint_pkg.sv
source/credit_link_if.sv
source/credit_fifo.sv
source/taint_prop_unit.sv
source/taint_tracker_top.sv
dv/taint_checker.sv
dv/taint_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := taint_tb
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Done: errors found
PASS_MSG  := Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
